//--- logic/div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DIV_WIDTH 32
`define DIV_STAGES `DIV_WIDTH  // One restoring step per stage

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tags and op code
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DIV_ADDR_WIDTH 8
`define DIV_PC_WIDTH 32
`define DIV_OP_WIDTH 4

// Any other op code returns the remainder
`define DIV_OP_QUOTIENT 4'b0001

`endif

//--- logic/div_pkg.sv
`include "div_settings.svh"

package div_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand and result words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Dividend, divisor, quotient or remainder
    typedef logic [`DIV_WIDTH-1:0] div_word_t;

    // Upper half is the partial remainder,
    // lower half collects quotient bits
    typedef logic [2*`DIV_WIDTH-1:0] div_work_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tags carried alongside
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`DIV_ADDR_WIDTH-1:0] div_addr_t;  // Physical register
    typedef logic [`DIV_PC_WIDTH-1:0] div_pc_t;
    typedef logic [`DIV_OP_WIDTH-1:0] div_op_t;

endpackage

//--- logic/div_stage_if.sv
`timescale 1ns/1ps

// One pipeline slot of the divider
interface div_stage_if;

    logic valid;  // Low means bubble
    logic div_zero;
    div_pkg::div_work_t work;
    div_pkg::div_word_t divisor;
    div_pkg::div_op_t op;
    div_pkg::div_addr_t addr;
    div_pkg::div_pc_t pc;

    // Producer side of a slot
    modport upstream (
        output valid,
        output div_zero,
        output work,
        output divisor,
        output op,
        output addr,
        output pc
    );

    // Consumer side of a slot
    modport downstream (
        input valid,
        input div_zero,
        input work,
        input divisor,
        input op,
        input addr,
        input pc
    );

endinterface

//--- logic/div_issue.sv
`timescale 1ns/1ps

`include "div_settings.svh"

// Entry point of the pipeline. Purely combinational,
// stage 0 registers whatever is presented here.
module div_issue (
    input logic start,
    input div_pkg::div_word_t a,
    input div_pkg::div_word_t b,
    input div_pkg::div_addr_t addr_in,
    input div_pkg::div_pc_t pc_in,
    input div_pkg::div_op_t op_in,
    div_stage_if.upstream out
);

    logic zero_divisor;
    div_pkg::div_work_t first_work;

    assign zero_divisor = (b == '0);

    // Dividend pre-shifted so stage 0 sees its MSB in the remainder half
    assign first_work = {{`DIV_WIDTH{1'b0}}, a} << 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        out.valid = start;
        out.div_zero = start && zero_divisor;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (zero_divisor) begin
            // All-ones divisor fails every compare, so quotient and remainder end at 0
            out.work = '0;
            out.divisor = '1;
        end else begin
            out.work = first_work;
            out.divisor = b;
        end
    end

    // Tags ride along untouched
    always_comb begin
        out.op = op_in;
        out.addr = addr_in;
        out.pc = pc_in;
    end

endmodule

//--- logic/div_stage.sv
`timescale 1ns/1ps

`include "div_settings.svh"

// One restoring compare-subtract step plus its pipeline register
module div_stage #(
    parameter bit last_stage = 1'b0  // Final stage keeps the remainder unshifted
) (
    input logic clk,
    input logic reset,
    div_stage_if.downstream prev,
    div_stage_if.upstream next
);

    div_pkg::div_word_t part_rem;
    div_pkg::div_work_t stepped;
    div_pkg::div_work_t shifted;

    assign part_rem = prev.work[2*`DIV_WIDTH-1:`DIV_WIDTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare and subtract
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (part_rem >= prev.divisor) begin
            // Subtract and record a 1 quotient bit
            stepped = {part_rem - prev.divisor, prev.work[`DIV_WIDTH-1:1], 1'b1};
        end else begin
            stepped = {prev.work[2*`DIV_WIDTH-1:1], 1'b0};  // Restore, bit is 0
        end
    end

    // Bring the next dividend bit into the remainder half
    assign shifted = last_stage ? stepped : (stepped << 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            next.valid <= 1'b0;
            next.div_zero <= 1'b0;
        end else begin
            next.valid <= prev.valid;
            next.div_zero <= prev.div_zero;
        end
    end

    always_ff @(posedge clk) begin
        next.work <= shifted;
        next.divisor <= prev.divisor;
        next.op <= prev.op;
        next.addr <= prev.addr;
        next.pc <= prev.pc;
    end

endmodule

//--- logic/div_retire.sv
`timescale 1ns/1ps

`include "div_settings.svh"

// Picks quotient or remainder from the last slot
module div_retire (
    div_stage_if.downstream final_entry,
    output div_pkg::div_word_t result,
    output logic done,
    output logic div_zero_exception,
    output div_pkg::div_addr_t addr_out,
    output div_pkg::div_pc_t pc_out
);

    logic want_quotient;

    assign want_quotient = (final_entry.op == `DIV_OP_QUOTIENT);

    always_comb begin
        if (want_quotient) begin
            result = final_entry.work[`DIV_WIDTH-1:0];
        end else begin
            // Remainder sits in the upper half
            result = final_entry.work[2*`DIV_WIDTH-1:`DIV_WIDTH];
        end
    end

    assign done = final_entry.valid;  // One cycle per issued op
    assign div_zero_exception = final_entry.div_zero;
    assign addr_out = final_entry.addr;
    assign pc_out = final_entry.pc;

endmodule

//--- logic/pipelined_divider.sv
`timescale 1ns/1ps

`include "div_settings.svh"

// Fully pipelined unsigned divider, one result per clock.
// Latency is DIV_STAGES edges counting the start edge.
module pipelined_divider (
    input logic clk,
    input logic reset,

    // Issue side
    input logic start,
    input div_pkg::div_word_t a,
    input div_pkg::div_word_t b,
    input div_pkg::div_addr_t addr_in,
    input div_pkg::div_pc_t pc_in,
    input div_pkg::div_op_t op_in,

    // Result side
    output div_pkg::div_word_t result,
    output logic done,
    output logic div_zero_exception,
    output div_pkg::div_addr_t addr_out,
    output div_pkg::div_pc_t pc_out
);

    // Slot 0 is combinational from the issue logic, the rest are registered
    div_stage_if stage_bus [`DIV_STAGES+1] ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    div_issue i_div_issue (
        .start(start),
        .a(a),
        .b(b),
        .addr_in(addr_in),
        .pc_in(pc_in),
        .op_in(op_in),
        .out(stage_bus[0])
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Step pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    genvar k;
    generate
        for (k = 0; k < `DIV_STAGES; k++) begin : g_stage
            div_stage #(
                .last_stage(k == `DIV_STAGES-1)  // No shift after the final step
            ) i_div_stage (
                .clk(clk),
                .reset(reset),
                .prev(stage_bus[k]),
                .next(stage_bus[k+1])
            );
        end
    endgenerate

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Retire
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    div_retire i_div_retire (
        .final_entry(stage_bus[`DIV_STAGES]),
        .result(result),
        .done(done),
        .div_zero_exception(div_zero_exception),
        .addr_out(addr_out),
        .pc_out(pc_out)
    );

endmodule

//--- sim/divider_tb.sv
`timescale 1ns/1ps

`include "div_settings.svh"

module divider_tb;

    localparam int CLK_PERIOD = 4;
    localparam int N_FIXED = 14;
    localparam int N_TESTS = 64;

    typedef struct {
        int id;
        int start_cycle;  // Edge that sampled start
        div_pkg::div_word_t result;
        logic flag;
        div_pkg::div_addr_t addr;
        div_pkg::div_pc_t pc;
    } exp_rec_t;

    logic clk = 1'b0;
    logic reset;
    logic start;
    div_pkg::div_word_t a;
    div_pkg::div_word_t b;
    div_pkg::div_addr_t addr_in;
    div_pkg::div_pc_t pc_in;
    div_pkg::div_op_t op_in;
    div_pkg::div_word_t result;
    logic done;
    logic div_zero_exception;
    div_pkg::div_addr_t addr_out;
    div_pkg::div_pc_t pc_out;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    div_pkg::div_word_t tab_a [N_TESTS];
    div_pkg::div_word_t tab_b [N_TESTS];
    div_pkg::div_op_t tab_op [N_TESTS];
    div_pkg::div_addr_t tab_addr [N_TESTS];
    div_pkg::div_pc_t tab_pc [N_TESTS];
    int tab_gap [N_TESTS];  // Idle cycles after the entry

    exp_rec_t pending [$];
    exp_rec_t got;
    integer seed = 12;
    int cycle = 0;
    int error_count = 0;
    int checked_count = 0;
    int errs_before;
    int watch_cycles;
    logic table_ready = 1'b0;

    pipelined_divider i_pipelined_divider (
        .clk(clk),
        .reset(reset),
        .start(start),
        .a(a),
        .b(b),
        .addr_in(addr_in),
        .pc_in(pc_in),
        .op_in(op_in),
        .result(result),
        .done(done),
        .div_zero_exception(div_zero_exception),
        .addr_out(addr_out),
        .pc_out(pc_out)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // Reference result straight from the divide rules
    function automatic div_pkg::div_word_t expected_result(input div_pkg::div_word_t dividend,
                                                           input div_pkg::div_word_t divisor,
                                                           input div_pkg::div_op_t op);
        if (divisor == '0)
            return '0;
        if (op == `DIV_OP_QUOTIENT)
            return dividend / divisor;
        return dividend % divisor;
    endfunction

    task automatic check_word(input string name, input div_pkg::div_word_t exp,
                              input div_pkg::div_word_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input div_pkg::div_addr_t exp,
                              input div_pkg::div_addr_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_pc(input string name, input div_pkg::div_pc_t exp,
                            input div_pkg::div_pc_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic set_entry(input int idx, input div_pkg::div_word_t dividend,
                             input div_pkg::div_word_t divisor, input div_pkg::div_op_t op,
                             input int gap);
        tab_a[idx] = dividend;
        tab_b[idx] = divisor;
        tab_op[idx] = op;
        tab_addr[idx] = idx[7:0];
        tab_pc[idx] = 32'h0000_1000 + 32'(idx << 2);
        tab_gap[idx] = gap;
    endtask

    task automatic load_corner_cases();
        set_entry(0, 32'd100, 32'd7, `DIV_OP_QUOTIENT, 0);
        set_entry(1, 32'd100, 32'd7, 4'b0000, 0);
        set_entry(2, 32'd5, 32'd9, `DIV_OP_QUOTIENT, 0);  // a below b
        set_entry(3, 32'd5, 32'd9, 4'b0010, 0);
        set_entry(4, 32'hffff_ffff, 32'd1, `DIV_OP_QUOTIENT, 0);
        set_entry(5, 32'hffff_ffff, 32'd1, 4'b1111, 0);
        set_entry(6, 32'hffff_ffff, 32'hffff_ffff, `DIV_OP_QUOTIENT, 0);
        set_entry(7, 32'hffff_ffff, 32'hffff_ffff, 4'b0000, 2);
        set_entry(8, 32'd1234, 32'd0, `DIV_OP_QUOTIENT, 0);  // Divide by zero
        set_entry(9, 32'd1234, 32'd0, 4'b0010, 0);
        set_entry(10, 32'd0, 32'd0, `DIV_OP_QUOTIENT, 0);
        set_entry(11, 32'd0, 32'd0, 4'b1111, 1);
        set_entry(12, 32'h8000_0000, 32'd3, `DIV_OP_QUOTIENT, 3);
        set_entry(13, 32'hdead_beef, 32'h0000_0010, 4'b0000, 1);
    endtask

    task automatic load_random_cases();
        logic [31:0] r;
        logic [31:0] shift;
        for (int i = N_FIXED; i < N_TESTS; i++) begin
            r = $random(seed);
            tab_a[i] = r;
            r = $random(seed);
            shift = $random(seed);
            tab_b[i] = r >> shift[4:0];  // Spread divisor sizes
            if (shift[7:5] == 3'd0)
                tab_b[i] = '0;
            r = $random(seed);
            tab_op[i] = r[0] ? `DIV_OP_QUOTIENT : r[7:4];
            tab_addr[i] = r[15:8];
            tab_pc[i] = $random(seed);
            tab_gap[i] = (r[19:17] == 3'd0) ? int'(r[21:20]) : 0;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            if (done === 1'b1) begin
                if (pending.size() == 0) begin
                    $display("Done went high at %0t with no operation in flight", $time);
                    error_count++;
                end else begin
                    got = pending.pop_front();
                    errs_before = error_count;
                    if (cycle - got.start_cycle != `DIV_STAGES - 1) begin
                        $display("Test %0d finished %0d edges after its start instead of %0d",
                                 got.id, cycle - got.start_cycle + 1, `DIV_STAGES);
                        error_count++;
                    end
                    check_word("result", got.result, result);
                    check_flag("div_zero_exception", got.flag, div_zero_exception);
                    check_addr("addr_out", got.addr, addr_out);
                    check_pc("pc_out", got.pc, pc_out);
                    if (error_count == errs_before)
                        $display("Test %0d passed", got.id);
                    else
                        $display("Test %0d failed", got.id);
                    checked_count++;
                end
            end else if (done === 1'b0) begin
                if (checked_count == 0)
                    check_flag("div_zero_exception", 1'b0, div_zero_exception);  // Idle flag
            end else begin
                $display("Done is unknown at %0t", $time);
                error_count++;
            end
        end
    end

    // Watchdog armed once the table length is known
    initial begin
        wait (table_ready === 1'b1);
        #(watch_cycles * CLK_PERIOD);
        $display("Timeout: only %0d of %0d results arrived", checked_count, N_TESTS);
        $display("Errors found");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        reset = 1'b1;
        start = 1'b0;
        a = '0;
        b = '0;
        addr_in = '0;
        pc_in = '0;
        op_in = '0;

        load_corner_cases();
        load_random_cases();
        watch_cycles = N_TESTS + `DIV_STAGES + 20;
        for (int i = 0; i < N_TESTS; i++)
            watch_cycles += tab_gap[i];
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < N_TESTS; i++) begin
            @(negedge clk);
            start = 1'b1;
            a = tab_a[i];
            b = tab_b[i];
            addr_in = tab_addr[i];
            pc_in = tab_pc[i];
            op_in = tab_op[i];
            pending.push_back('{i, cycle + 1, expected_result(tab_a[i], tab_b[i], tab_op[i]),
                                tab_b[i] == '0, tab_addr[i], tab_pc[i]});
            for (int g = 0; g < tab_gap[i]; g++) begin
                @(negedge clk);
                start = 1'b0;  // Bubble
            end
        end
        @(negedge clk);
        start = 1'b0;

        wait (checked_count == N_TESTS);
        repeat (4) @(negedge clk);  // Catch any stray done

        $display("Tests: %0d, checked: %0d, errors: %0d", N_TESTS, checked_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/div_pkg.sv
logic/div_stage_if.sv
logic/div_issue.sv
logic/div_stage.sv
logic/div_retire.sv
logic/pipelined_divider.sv
sim/divider_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the divider testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

TOP=divider_tb
OBJ_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

rm -rf "$OBJ_DIR"
status=$?
if [ $status -ne 0 ]; then
    echo "Could not clean $OBJ_DIR"
    exit $status
fi

rm -f "$LOG"

# Compile and build the simulation binary
verilator --binary --timing --timescale 1ns/1ps \
    -f filelist.f \
    --top-module "$TOP" \
    -Mdir "$OBJ_DIR" \
    -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

# Run, keeping the output in a log
"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

if grep -q "^No errors$" "$LOG"; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi
